//--- glb_bank_controller.sv
// Global buffer bank controller
`timescale 1ns/1ps

module glb_bank_controller (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  host_wr_sel,
    input  logic                  host_rd_sel,
    input  logic                  cgra_wr_sel,
    input  logic                  cgra_rd_sel,
    input  glb_pkg::bank_addr_t   host_wr_addr,
    input  glb_pkg::bank_addr_t   host_rd_addr,
    input  glb_pkg::bank_addr_t   cgra_wr_addr,
    input  glb_pkg::bank_addr_t   cgra_rd_addr,
    input  glb_pkg::word_t        host_wr_data,
    input  glb_pkg::word_t        cgra_wr_data,
    output glb_pkg::word_t        host_rd_data,
    output glb_pkg::word_t        cgra_rd_data
);

    // Memory core side.
    logic                mem_rd_en;
    logic                mem_wr_en;
    glb_pkg::bank_addr_t mem_addr;
    glb_pkg::word_t      mem_data_in;
    glb_pkg::word_t      mem_data_out;

    // Which port issued the read now leaving the core.
    logic host_rd_en_q;
    logic cgra_rd_en_q;
    // Last word returned to each port.
    glb_pkg::word_t host_rd_data_q;
    glb_pkg::word_t cgra_rd_data_q;

    // One access per cycle, host first.
    always_comb begin
        mem_wr_en   = 1'b0;
        mem_rd_en   = 1'b0;
        mem_addr    = '0;
        mem_data_in = '0;
        if (host_wr_sel) begin
            mem_wr_en   = 1'b1;
            mem_addr    = host_wr_addr;
            mem_data_in = host_wr_data;
        end else if (host_rd_sel) begin
            mem_rd_en   = 1'b1;
            mem_addr    = host_rd_addr;
        end else if (cgra_wr_sel) begin
            mem_wr_en   = 1'b1;
            mem_addr    = cgra_wr_addr;
            mem_data_in = cgra_wr_data;
        end else if (cgra_rd_sel) begin
            mem_rd_en   = 1'b1;
            mem_addr    = cgra_rd_addr;
        end
    end

    glb_mem_core i_mem_core (
        .clk      (clk),
        .rd_en    (mem_rd_en),
        .wr_en    (mem_wr_en),
        .addr     (mem_addr),
        .data_in  (mem_data_in),
        .data_out (mem_data_out)
    );

    // Track the read owner and keep the last returned words.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            host_rd_en_q   <= 1'b0;
            cgra_rd_en_q   <= 1'b0;
            host_rd_data_q <= '0;
            cgra_rd_data_q <= '0;
        end else begin
            host_rd_en_q   <= host_rd_sel & ~host_wr_sel;
            cgra_rd_en_q   <= cgra_rd_sel & ~host_wr_sel & ~host_rd_sel & ~cgra_wr_sel;
            host_rd_data_q <= host_rd_data;
            cgra_rd_data_q <= cgra_rd_data;
        end
    end

    // Fresh core data on the read's return cycle.
    // Held word otherwise.
    assign host_rd_data = host_rd_en_q ? mem_data_out : host_rd_data_q;
    assign cgra_rd_data = cgra_rd_en_q ? mem_data_out : cgra_rd_data_q;

    // Refused reads never reach the bank.
    assert property (@(posedge clk) disable iff (reset)
        !(host_wr_sel && host_rd_sel) && !(cgra_wr_sel && cgra_rd_sel));

    // Decoder already resolved host collisions for this bank.
    assert property (@(posedge clk) disable iff (reset)
        !((cgra_wr_sel || cgra_rd_sel) && (host_wr_sel || host_rd_sel)));

endmodule

//--- glb_consts.svh
// Global buffer constants
`ifndef GLB_CONSTS_SVH
`define GLB_CONSTS_SVH

// Number of banks in the buffer.
`define GLB_NUM_BANKS 4

// Width of one data word.
`define GLB_DATA_WIDTH 64

// Word address inside one bank.
// 256 words per bank.
`define GLB_BANK_ADDR_WIDTH 8

// Bank select field.
// Must cover GLB_NUM_BANKS.
`define GLB_BANK_IDX_WIDTH 2

// Full word address.
// Bank index sits in the upper bits.
`define GLB_ADDR_WIDTH 10

// Words held by one bank.
`define GLB_BANK_DEPTH (1 << `GLB_BANK_ADDR_WIDTH)

`endif

//--- glb_mem_core.sv
// Bank memory core
`timescale 1ns/1ps
`include "glb_consts.svh"

module glb_mem_core (
    input  logic                 clk,
    input  logic                 rd_en,
    input  logic                 wr_en,
    input  glb_pkg::bank_addr_t  addr,
    input  glb_pkg::word_t       data_in,
    output glb_pkg::word_t       data_out
);

    // Word storage of one bank.
    glb_pkg::word_t mem [`GLB_BANK_DEPTH];

    // Write on the enable edge.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= data_in;
        end
    end

    // Registered read.
    // Output keeps its word until the next read.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            data_out <= mem[addr];
        end
    end

endmodule

//--- glb_pkg.sv
// Global buffer types
`include "glb_consts.svh"

package glb_pkg;

    // One data word.
    typedef logic [`GLB_DATA_WIDTH-1:0] word_t;

    // Full word address, bank index on top.
    typedef logic [`GLB_ADDR_WIDTH-1:0] addr_t;

    // Word address inside a bank.
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // Bank index.
    typedef logic [`GLB_BANK_IDX_WIDTH-1:0] bank_idx_t;

    // One-hot bank mask.
    // One bit per bank.
    typedef logic [`GLB_NUM_BANKS-1:0] bank_mask_t;

endpackage

//--- glb_rd_return.sv
// Read data return mux
`timescale 1ns/1ps
`include "glb_consts.svh"

module glb_rd_return (
    input  logic                 clk,
    input  logic                 reset,
    input  glb_pkg::bank_mask_t  host_rd_sel,
    input  glb_pkg::bank_mask_t  cgra_rd_sel,
    input  glb_pkg::word_t       bank_host_rd_data [`GLB_NUM_BANKS],
    input  glb_pkg::word_t       bank_cgra_rd_data [`GLB_NUM_BANKS],
    output glb_pkg::word_t       host_rd_data,
    output glb_pkg::word_t       cgra_rd_data
);

    // Bank that served each port's last granted read.
    glb_pkg::bank_idx_t host_idx_q;
    glb_pkg::bank_idx_t cgra_idx_q;

    // One-hot mask to bank index.
    function automatic glb_pkg::bank_idx_t mask_to_idx(input glb_pkg::bank_mask_t mask);
        glb_pkg::bank_idx_t idx;
        idx = '0;
        for (int i = 0; i < `GLB_NUM_BANKS; i++) begin
            if (mask[i]) begin
                idx = glb_pkg::bank_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // Only a granted read moves the index.
    // Idle cycles keep pointing at the same bank.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            host_idx_q <= '0;
            cgra_idx_q <= '0;
        end else begin
            if (|host_rd_sel) begin
                host_idx_q <= mask_to_idx(host_rd_sel);
            end
            if (|cgra_rd_sel) begin
                cgra_idx_q <= mask_to_idx(cgra_rd_sel);
            end
        end
    end

    // Bank outputs already hold between reads.
    assign host_rd_data = bank_host_rd_data[host_idx_q];
    assign cgra_rd_data = bank_cgra_rd_data[cgra_idx_q];

    // Each granted read names one bank at most.
    assert property (@(posedge clk) disable iff (reset)
        $onehot0(host_rd_sel) && $onehot0(cgra_rd_sel));

endmodule

//--- glb_req_decoder.sv
// Bank request decoder
`timescale 1ns/1ps
`include "glb_consts.svh"

module glb_req_decoder (
    input  logic                   host_wr_en,
    input  glb_pkg::addr_t         host_wr_addr,
    input  logic                   host_rd_en,
    input  glb_pkg::addr_t         host_rd_addr,
    input  logic                   cgra_wr_en,
    input  glb_pkg::addr_t         cgra_wr_addr,
    input  logic                   cgra_rd_en,
    input  glb_pkg::addr_t         cgra_rd_addr,
    output glb_pkg::bank_mask_t    host_wr_sel,
    output glb_pkg::bank_mask_t    host_rd_sel,
    output glb_pkg::bank_mask_t    cgra_wr_sel,
    output glb_pkg::bank_mask_t    cgra_rd_sel,
    output glb_pkg::bank_addr_t    host_wr_bank_addr,
    output glb_pkg::bank_addr_t    host_rd_bank_addr,
    output glb_pkg::bank_addr_t    cgra_wr_bank_addr,
    output glb_pkg::bank_addr_t    cgra_rd_bank_addr,
    output logic                   cgra_stall
);

    // Raw per-bank requests before arbitration.
    glb_pkg::bank_mask_t host_rd_req;
    glb_pkg::bank_mask_t cgra_wr_req;
    glb_pkg::bank_mask_t cgra_rd_req;
    // Banks touched by any host enable this cycle.
    glb_pkg::bank_mask_t host_busy;

    // Enable plus address to one-hot bank mask.
    function automatic glb_pkg::bank_mask_t bank_mask(input logic en,
                                                      input glb_pkg::addr_t addr);
        glb_pkg::bank_idx_t idx;
        idx = addr[`GLB_ADDR_WIDTH-1 -: `GLB_BANK_IDX_WIDTH];
        if (en) begin
            return glb_pkg::bank_mask_t'(1) << idx;
        end
        return '0;
    endfunction

    always_comb begin
        host_wr_sel = bank_mask(host_wr_en, host_wr_addr);
        host_rd_req = bank_mask(host_rd_en, host_rd_addr);
        cgra_wr_req = bank_mask(cgra_wr_en, cgra_wr_addr);
        cgra_rd_req = bank_mask(cgra_rd_en, cgra_rd_addr);
        host_busy   = host_wr_sel | host_rd_req;
        // Host write beats host read in one bank. Not signalled.
        host_rd_sel = host_rd_req & ~host_wr_sel;
        // Any host use of a bank blocks the CGRA there.
        cgra_wr_sel = cgra_wr_req & ~host_busy;
        // CGRA write beats CGRA read in one bank. Not signalled.
        cgra_rd_sel = cgra_rd_req & ~host_busy & ~cgra_wr_sel;
        // Stall only on host collisions.
        cgra_stall  = |((cgra_wr_req | cgra_rd_req) & host_busy);
    end

    // In-bank word address for every bank.
    assign host_wr_bank_addr = host_wr_addr[`GLB_BANK_ADDR_WIDTH-1:0];
    assign host_rd_bank_addr = host_rd_addr[`GLB_BANK_ADDR_WIDTH-1:0];
    assign cgra_wr_bank_addr = cgra_wr_addr[`GLB_BANK_ADDR_WIDTH-1:0];
    assign cgra_rd_bank_addr = cgra_rd_addr[`GLB_BANK_ADDR_WIDTH-1:0];

endmodule

//--- glb_top.sv
// Banked global buffer top
`timescale 1ns/1ps
`include "glb_consts.svh"

module glb_top (
    input  logic              clk,
    input  logic              reset,
    // Host side.
    input  logic              host_wr_en,
    input  glb_pkg::addr_t    host_wr_addr,
    input  glb_pkg::word_t    host_wr_data,
    input  logic              host_rd_en,
    input  glb_pkg::addr_t    host_rd_addr,
    output glb_pkg::word_t    host_rd_data,
    // CGRA side.
    input  logic              cgra_wr_en,
    input  glb_pkg::addr_t    cgra_wr_addr,
    input  glb_pkg::word_t    cgra_wr_data,
    input  logic              cgra_rd_en,
    input  glb_pkg::addr_t    cgra_rd_addr,
    output glb_pkg::word_t    cgra_rd_data,
    output logic              cgra_stall
);

    // Granted per-bank requests.
    glb_pkg::bank_mask_t host_wr_sel;
    glb_pkg::bank_mask_t host_rd_sel;
    glb_pkg::bank_mask_t cgra_wr_sel;
    glb_pkg::bank_mask_t cgra_rd_sel;
    // In-bank addresses, shared by all banks.
    glb_pkg::bank_addr_t host_wr_bank_addr;
    glb_pkg::bank_addr_t host_rd_bank_addr;
    glb_pkg::bank_addr_t cgra_wr_bank_addr;
    glb_pkg::bank_addr_t cgra_rd_bank_addr;
    // Held read words of every bank.
    glb_pkg::word_t bank_host_rd_data [`GLB_NUM_BANKS];
    glb_pkg::word_t bank_cgra_rd_data [`GLB_NUM_BANKS];

    glb_req_decoder i_req_decoder (
        .host_wr_en        (host_wr_en),
        .host_wr_addr      (host_wr_addr),
        .host_rd_en        (host_rd_en),
        .host_rd_addr      (host_rd_addr),
        .cgra_wr_en        (cgra_wr_en),
        .cgra_wr_addr      (cgra_wr_addr),
        .cgra_rd_en        (cgra_rd_en),
        .cgra_rd_addr      (cgra_rd_addr),
        .host_wr_sel       (host_wr_sel),
        .host_rd_sel       (host_rd_sel),
        .cgra_wr_sel       (cgra_wr_sel),
        .cgra_rd_sel       (cgra_rd_sel),
        .host_wr_bank_addr (host_wr_bank_addr),
        .host_rd_bank_addr (host_rd_bank_addr),
        .cgra_wr_bank_addr (cgra_wr_bank_addr),
        .cgra_rd_bank_addr (cgra_rd_bank_addr),
        .cgra_stall        (cgra_stall)
    );

    // One controller and core per bank.
    for (genvar b = 0; b < `GLB_NUM_BANKS; b++) begin : g_bank
        glb_bank_controller i_bank_controller (
            .clk          (clk),
            .reset        (reset),
            .host_wr_sel  (host_wr_sel[b]),
            .host_rd_sel  (host_rd_sel[b]),
            .cgra_wr_sel  (cgra_wr_sel[b]),
            .cgra_rd_sel  (cgra_rd_sel[b]),
            .host_wr_addr (host_wr_bank_addr),
            .host_rd_addr (host_rd_bank_addr),
            .cgra_wr_addr (cgra_wr_bank_addr),
            .cgra_rd_addr (cgra_rd_bank_addr),
            .host_wr_data (host_wr_data),
            .cgra_wr_data (cgra_wr_data),
            .host_rd_data (bank_host_rd_data[b]),
            .cgra_rd_data (bank_cgra_rd_data[b])
        );
    end

    glb_rd_return i_rd_return (
        .clk               (clk),
        .reset             (reset),
        .host_rd_sel       (host_rd_sel),
        .cgra_rd_sel       (cgra_rd_sel),
        .bank_host_rd_data (bank_host_rd_data),
        .bank_cgra_rd_data (bank_cgra_rd_data),
        .host_rd_data      (host_rd_data),
        .cgra_rd_data      (cgra_rd_data)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the global buffer testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_glb_top \
    --Mdir obj_dir \
    -o sim_glb \
    -f vlog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_glb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi

exit 0

//--- tb_glb_top.sv
// Global buffer testbench
`timescale 1ns/1ps
`include "glb_consts.svh"

module tb_glb_top;

    // Run limit. The phases need about 2200 cycles.
    localparam int MAX_CYCLES    = 3000;
    localparam int RANDOM_CYCLES = 1500;
    // Half the address space. Banks 0 and 1 lie below it.
    localparam int HALF_SPACE    = (1 << `GLB_ADDR_WIDTH) / 2;

    logic                clk;
    logic                reset;
    logic                host_wr_en;
    glb_pkg::addr_t      host_wr_addr;
    glb_pkg::word_t      host_wr_data;
    logic                host_rd_en;
    glb_pkg::addr_t      host_rd_addr;
    glb_pkg::word_t      host_rd_data;
    logic                cgra_wr_en;
    glb_pkg::addr_t      cgra_wr_addr;
    glb_pkg::word_t      cgra_wr_data;
    logic                cgra_rd_en;
    glb_pkg::addr_t      cgra_rd_addr;
    glb_pkg::word_t      cgra_rd_data;
    logic                cgra_stall;

    // Reference copy of the whole address space.
    glb_pkg::word_t mirror [1 << `GLB_ADDR_WIDTH];
    // Word owed to each read request.
    // Set when it is issued.
    glb_pkg::word_t exp_host_req;
    glb_pkg::word_t exp_cgra_req;
    // CGRA read got through.
    logic           exp_cgra_go;
    logic           exp_stall;
    // Word each read port should show.
    glb_pkg::word_t exp_host_rd;
    glb_pkg::word_t exp_cgra_rd;
    int             cycle_count = 0;

    glb_top i_glb_top (
        .clk          (clk),
        .reset        (reset),
        .host_wr_en   (host_wr_en),
        .host_wr_addr (host_wr_addr),
        .host_wr_data (host_wr_data),
        .host_rd_en   (host_rd_en),
        .host_rd_addr (host_rd_addr),
        .host_rd_data (host_rd_data),
        .cgra_wr_en   (cgra_wr_en),
        .cgra_wr_addr (cgra_wr_addr),
        .cgra_wr_data (cgra_wr_data),
        .cgra_rd_en   (cgra_rd_en),
        .cgra_rd_addr (cgra_rd_addr),
        .cgra_rd_data (cgra_rd_data),
        .cgra_stall   (cgra_stall)
    );

    // 10 ns clock.
    always #5 clk = ~clk;

    // Print the cause and end the run.
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    // Bank index from the upper address bits.
    function automatic glb_pkg::bank_idx_t bank_of(input glb_pkg::addr_t addr);
        return addr[`GLB_ADDR_WIDTH-1 -: `GLB_BANK_IDX_WIDTH];
    endfunction

    // Start-up contents.
    // Distinct for every address.
    function automatic glb_pkg::word_t fill_word(input glb_pkg::addr_t addr);
        return {16'hC0DE, 6'd0, addr, 6'd0, ~addr, 16'h5A5A};
    endfunction

    // Random word address inside one bank.
    function automatic glb_pkg::addr_t addr_in_bank(input int bank);
        return {glb_pkg::bank_idx_t'(bank), glb_pkg::bank_addr_t'($urandom)};
    endfunction

    function automatic glb_pkg::word_t rand_word();
        return {$urandom, $urandom};
    endfunction

    // One request cycle.
    // Model updated in request order.
    task automatic drive_cycle(input logic hw_en, input glb_pkg::addr_t hw_addr,
                               input glb_pkg::word_t hw_data,
                               input logic hr_en, input glb_pkg::addr_t hr_addr,
                               input logic cw_en, input glb_pkg::addr_t cw_addr,
                               input glb_pkg::word_t cw_data,
                               input logic cr_en, input glb_pkg::addr_t cr_addr);
        glb_pkg::bank_mask_t host_use;
        logic                cw_ok;
        logic                cr_ok;
        host_use = '0;
        if (hw_en) host_use[bank_of(hw_addr)] = 1'b1;
        if (hr_en) host_use[bank_of(hr_addr)] = 1'b1;
        // CGRA loses any bank the host touches.
        cw_ok = cw_en && !host_use[bank_of(cw_addr)];
        cr_ok = cr_en && !host_use[bank_of(cr_addr)];
        // Reads see memory before this cycle's writes.
        if (hr_en) exp_host_req <= mirror[hr_addr];
        if (cr_ok) exp_cgra_req <= mirror[cr_addr];
        if (hw_en) mirror[hw_addr] = hw_data;
        if (cw_ok) mirror[cw_addr] = cw_data;
        exp_cgra_go  <= cr_ok;
        exp_stall    <= (cw_en && !cw_ok) || (cr_en && !cr_ok);
        host_wr_en   <= hw_en;
        host_wr_addr <= hw_addr;
        host_wr_data <= hw_data;
        host_rd_en   <= hr_en;
        host_rd_addr <= hr_addr;
        cgra_wr_en   <= cw_en;
        cgra_wr_addr <= cw_addr;
        cgra_wr_data <= cw_data;
        cgra_rd_en   <= cr_en;
        cgra_rd_addr <= cr_addr;
        @(posedge clk);
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, '0, 1'b0, '0);
    endtask

    // Expected port words move one edge after the request is sampled.
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            exp_host_rd <= '0;
            exp_cgra_rd <= '0;
        end else begin
            if (host_rd_en) exp_host_rd <= exp_host_req;
            if (exp_cgra_go) exp_cgra_rd <= exp_cgra_req;
        end
    end

    // Hang guard.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout, run not done after %0d cycles", cycle_count));
        end
    end

    // Read ports match the model every cycle.
    // Holds are included.
    assert property (@(posedge clk) disable iff (reset) host_rd_data == exp_host_rd)
        else abort_run($sformatf("MISMATCH host_rd_data: got %h expected %h",
                                 $sampled(host_rd_data), $sampled(exp_host_rd)));
    assert property (@(posedge clk) disable iff (reset) cgra_rd_data == exp_cgra_rd)
        else abort_run($sformatf("MISMATCH cgra_rd_data: got %h expected %h",
                                 $sampled(cgra_rd_data), $sampled(exp_cgra_rd)));
    // Stall flag follows the bank collision rule.
    assert property (@(posedge clk) disable iff (reset) cgra_stall == exp_stall)
        else abort_run($sformatf("MISMATCH cgra_stall: got %h expected %h",
                                 $sampled(cgra_stall), $sampled(exp_stall)));

    initial begin
        glb_pkg::addr_t a;
        glb_pkg::addr_t hw_a;
        glb_pkg::addr_t hr_a;
        glb_pkg::addr_t cw_a;
        glb_pkg::addr_t cr_a;
        logic           hw_e;
        logic           hr_e;
        logic           cw_e;
        logic           cr_e;
        void'($urandom(8));
        clk          = 1'b0;
        reset        = 1'b1;
        host_wr_en   = 1'b0;
        host_wr_addr = '0;
        host_wr_data = '0;
        host_rd_en   = 1'b0;
        host_rd_addr = '0;
        cgra_wr_en   = 1'b0;
        cgra_wr_addr = '0;
        cgra_wr_data = '0;
        cgra_rd_en   = 1'b0;
        cgra_rd_addr = '0;
        exp_host_req = '0;
        exp_cgra_req = '0;
        exp_cgra_go  = 1'b0;
        exp_stall    = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        idle(2);

        // Host fills banks 0 and 1 while CGRA fills banks 2 and 3.
        for (int i = 0; i < HALF_SPACE; i++) begin
            hw_a = glb_pkg::addr_t'(i);
            cw_a = glb_pkg::addr_t'(i + HALF_SPACE);
            drive_cycle(1'b1, hw_a, fill_word(hw_a), 1'b0, '0,
                        1'b1, cw_a, fill_word(cw_a), 1'b0, '0);
        end

        // Host write then read back in every bank.
        for (int b = 0; b < `GLB_NUM_BANKS; b++) begin
            for (int k = 0; k < 4; k++) begin
                a = addr_in_bank(b);
                drive_cycle(1'b1, a, rand_word(), 1'b0, '0, 1'b0, '0, '0, 1'b0, '0);
                drive_cycle(1'b0, '0, '0, 1'b1, a, 1'b0, '0, '0, 1'b0, '0);
            end
        end

        // Four ports on four different banks at once.
        for (int k = 0; k < 64; k++) begin
            drive_cycle(1'b1, addr_in_bank(k % 4), rand_word(),
                        1'b1, addr_in_bank((k + 1) % 4),
                        1'b1, addr_in_bank((k + 2) % 4), rand_word(),
                        1'b1, addr_in_bank((k + 3) % 4));
        end

        // Collisions per bank.
        // Each is followed by a clean CGRA read of a.
        for (int b = 0; b < `GLB_NUM_BANKS; b++) begin
            a = addr_in_bank(b);
            drive_cycle(1'b1, addr_in_bank(b), rand_word(), 1'b0, '0,
                        1'b1, a, rand_word(), 1'b0, '0);
            drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, '0, 1'b1, a);
            drive_cycle(1'b0, '0, '0, 1'b1, addr_in_bank(b),
                        1'b1, a, rand_word(), 1'b0, '0);
            drive_cycle(1'b0, '0, '0, 1'b1, addr_in_bank(b),
                        1'b0, '0, '0, 1'b1, addr_in_bank(b));
            drive_cycle(1'b1, addr_in_bank(b), rand_word(), 1'b0, '0,
                        1'b0, '0, '0, 1'b1, a);
            drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, '0, 1'b1, a);
            idle(2);
        end

        // Held words across idle time and the other port's reads.
        drive_cycle(1'b0, '0, '0, 1'b1, addr_in_bank(1), 1'b0, '0, '0, 1'b0, '0);
        idle(4);
        for (int b = 0; b < `GLB_NUM_BANKS; b++) begin
            drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, '0, 1'b1, addr_in_bank(b));
        end
        idle(4);
        drive_cycle(1'b0, '0, '0, 1'b1, addr_in_bank(3), 1'b0, '0, '0, 1'b0, '0);
        idle(4);

        // Random traffic.
        // Stalls arise by chance.
        for (int k = 0; k < RANDOM_CYCLES; k++) begin
            hw_e = ($urandom % 2) == 0;
            hr_e = ($urandom % 2) == 0;
            cw_e = ($urandom % 2) == 0;
            cr_e = ($urandom % 2) == 0;
            hw_a = glb_pkg::addr_t'($urandom);
            hr_a = glb_pkg::addr_t'($urandom);
            cw_a = glb_pkg::addr_t'($urandom);
            cr_a = glb_pkg::addr_t'($urandom);
            // Write and read of one side stay in different banks.
            if (hw_e && bank_of(hr_a) == bank_of(hw_a)) hr_e = 1'b0;
            if (cw_e && bank_of(cr_a) == bank_of(cw_a)) cr_e = 1'b0;
            drive_cycle(hw_e, hw_a, rand_word(), hr_e, hr_a,
                        cw_e, cw_a, rand_word(), cr_e, cr_a);
        end
        idle(4);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
glb_pkg.sv
glb_mem_core.sv
glb_bank_controller.sv
glb_req_decoder.sv
glb_rd_return.sv
glb_top.sv
tb_glb_top.sv
